/* bench/eeprom_model.sv */
`timescale 1ns/1ps

module eeprom_model #(
    parameter int BLOCKS_PRESENT = 8
) (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_low,
    output logic frame_open,
    output logic violation
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    data_t      mem [0:(1 << ADDR_W)-1];
    data_t      shreg;
    data_t      txreg;
    addr_t      ptr;
    logic [3:0] bit_cnt;    // scl rises counted in this byte
    logic [1:0] byte_idx;   // control, word address, data, then silent
    logic       scl_q;
    logic       sda_q;
    logic       tx;
    logic       rd_pending;
    logic       level;      // level the slave wants on sda

    initial
    begin
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[addr_t'(i)] = 8'hFF;   // blank device
    end

    task automatic flag_violation(input string what);
        $display("framing violation at %0t: %s", $time, what);
        violation = 1'b1;
    endtask

    // ack slot of a byte written by the master
    task automatic take_byte;
        case (byte_idx)
            2'd0:
            begin
                if (shreg[7:4] == DEVICE_CODE && int'(shreg[3:1]) < BLOCKS_PRESENT)
                begin
                    level      = ACK_LEVEL;
                    ptr        = {shreg[3:1], ptr[DATA_W-1:0]};
                    rd_pending = shreg[0];
                    byte_idx   = shreg[0] ? 2'd3 : 2'd1;
                end
                else
                    byte_idx = 2'd3;   // absent block stays silent
            end
            2'd1:
            begin
                level         = ACK_LEVEL;
                ptr[DATA_W-1:0] = shreg;
                byte_idx      = 2'd2;
            end
            2'd2:
            begin
                level     = ACK_LEVEL;
                mem[ptr]  = shreg;
                byte_idx  = 2'd3;
            end
            default: level = NACK_LEVEL;   // no page writes
        endcase
    endtask

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q      = 1'b1;
            sda_q      = 1'b1;
            bit_cnt    = 4'd0;
            byte_idx   = 2'd0;
            tx         = 1'b0;
            rd_pending = 1'b0;
            level      = 1'b1;
            frame_open = 1'b0;
            violation  = 1'b0;
        end
        else if (scl_q && scl && sda_q && !sda)
        begin
            // a repeated start or a stop follows one scl rise past the ack
            if (frame_open && bit_cnt != 4'd1)
                flag_violation("start condition in the middle of a byte");
            frame_open = 1'b1;
            bit_cnt    = 4'd0;
            byte_idx   = 2'd0;
            tx         = 1'b0;
            rd_pending = 1'b0;
            level      = 1'b1;
        end
        else if (scl_q && scl && !sda_q && sda)
        begin
            if (!frame_open || bit_cnt != 4'd1)
                flag_violation("stop condition without a start or inside a byte");
            frame_open = 1'b0;
            level      = 1'b1;
        end
        else if (!scl_q && scl)
        begin
            if (bit_cnt < 4'd8)
                shreg = {shreg[DATA_W-2:0], sda};
            bit_cnt = bit_cnt + 4'd1;
        end
        else if (scl_q && !scl)
        begin
            if (bit_cnt == 4'd9)
            begin
                bit_cnt = 4'd0;
                level   = 1'b1;
                if (tx)
                    tx = 1'b0;   // single byte reads only
                else if (rd_pending)
                begin
                    tx         = 1'b1;
                    rd_pending = 1'b0;
                    txreg      = mem[ptr];
                end
            end
            if (tx && bit_cnt < 4'd8)
            begin
                level = txreg[DATA_W-1];
                txreg = {txreg[DATA_W-2:0], 1'b1};
            end
            else if (bit_cnt == 4'd8)
            begin
                level = 1'b1;   // free for the master's nack
                if (!tx)
                    take_byte();
            end
        end
        scl_q = scl;
        sda_q = sda;
        sda_low <= !level;
    end

endmodule

/* bench/tb_eeprom.sv */
`timescale 1ns/1ps

module tb_eeprom;
    import eeprom_pkg::*;

    localparam int    N_RANDOM    = 32;
    localparam int    CYCLE_LIMIT = 2 * N_RANDOM * 400 + 100;   // 400 cycles per transfer
    localparam addr_t POKE_ADDR   = 11'h25E;

    logic        CLK = 1'b0;
    logic        RESET;
    logic        wr;
    logic        rd;
    addr_t       addr;
    data_t       wdata;
    logic        busy;
    logic        done;
    logic        nack_err;
    data_t       rdata;
    logic        scl;
    logic        sda_low;
    logic        model_low;
    logic        sda;
    logic        frame_open;
    logic        violation;
    data_t       ref_mem [0:(1 << ADDR_W)-1];
    logic [16:0] lfsr = 17'd87370;
    int          cycles = 0;
    int          accepted = 0;
    int          done_count = 0;
    logic        pending = 1'b0;
    logic        exp_read;
    logic        exp_nack;
    data_t       exp_rdata;
    data_t       last_rdata = '0;

    assign sda = !sda_low && !model_low;   // open drain, wired and

    eeprom_if_top #(.QUARTER(2)) dut0 (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .busy(busy), .done(done), .nack_err(nack_err), .rdata(rdata),
        .scl(scl), .sda_low(sda_low), .sda_in(sda)
    );

    eeprom_model #(.BLOCKS_PRESENT(6)) slave0 (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda), .sda_low(model_low),
        .frame_open(frame_open), .violation(violation)
    );

    always #20 CLK = ~CLK;

    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};   // x^17 + x^14 + 1
    endfunction

    task automatic draw(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    function automatic data_t expected_read(input addr_t a);
        return ref_mem[a];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            abort_run($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            abort_run($sformatf("error %s got %0h expected %0h", name, got, exp));
    endtask

    task automatic transfer(input logic is_write, input addr_t a, input data_t d,
                            input logic poke);
        @(negedge CLK);
        wr    <= is_write;
        rd    <= !is_write;
        addr  <= a;
        wdata <= d;
        exp_read = !is_write;
        exp_nack = (a[ADDR_W-1:DATA_W] > 3'd5);   // blocks 6 and 7 absent
        if (!is_write && !exp_nack)
            last_rdata = expected_read(a);
        exp_rdata = last_rdata;
        if (is_write && !exp_nack)
            ref_mem[a] = d;
        pending = 1'b1;
        accepted++;
        @(negedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        check_flag("busy", busy, 1'b1);
        if (poke)
        begin
            @(negedge CLK);
            wr    <= 1'b1;
            rd    <= 1'b1;
            addr  <= POKE_ADDR;
            wdata <= ~d;
            @(negedge CLK);
            wr <= 1'b0;
            rd <= 1'b0;
        end
        do
            @(negedge CLK);
        while (!done);
    endtask

    always @(negedge CLK)
    begin
        if (violation)
            abort_run("the EEPROM model reported a bus framing violation");
        if (done)
        begin
            if (!pending)
                abort_run("done pulsed with no transfer pending");
            done_count++;
            pending = 1'b0;
            check_flag("nack_err", nack_err, exp_nack);
            check_flag("busy", busy, 1'b0);
            check_flag("frame_open", frame_open, 1'b0);   // closed by a stop
            if (exp_read)
                check_data("rdata", rdata, exp_rdata);
        end
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT)
            abort_run("timeout, the transfers did not finish within the cycle limit");
    end

    initial
    begin
        logic [15:0] r;
        logic [2:0]  blk;
        addr_t       a;
        addr_t       first_addr;
        data_t       d;
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < (1 << ADDR_W); i++)
            ref_mem[addr_t'(i)] = 8'hFF;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        repeat (2) @(negedge CLK);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("nack_err", nack_err, 1'b0);
        check_flag("scl", scl, 1'b1);
        check_flag("sda_low", sda_low, 1'b0);
        for (int k = 0; k < N_RANDOM; k++)
        begin
            draw(3, r);
            blk = r[2:0];
            if (blk > 3'd5)
                blk = blk - 3'd6;   // present blocks only
            draw(8, r);
            a = {blk, r[7:0]};
            draw(8, r);
            d = r[7:0];
            if (k == 0)
                first_addr = a;
            transfer(1'b1, a, d, 1'b0);
            transfer(1'b0, a, 8'h00, 1'b0);
        end
        transfer(1'b1, first_addr, ~expected_read(first_addr), 1'b0);
        transfer(1'b0, first_addr, 8'h00, 1'b0);
        transfer(1'b1, 11'h612, 8'h5A, 1'b0);
        transfer(1'b0, 11'h734, 8'h00, 1'b0);
        transfer(1'b1, 11'h1C3, 8'h3C, 1'b1);   // strobes while busy
        transfer(1'b0, POKE_ADDR, 8'h00, 1'b0);
        transfer(1'b0, 11'h1C3, 8'h00, 1'b0);
        repeat (20) @(negedge CLK);
        check_count("done_count", done_count, accepted);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* filelist.f */
src/i2c_pkg.sv
src/eeprom_pkg.sv
src/bus_timer.sv
src/bus_condition.sv
src/byte_shifter.sv
src/eeprom_ctrl.sv
src/eeprom_if_top.sv
bench/eeprom_model.sv
bench/tb_eeprom.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then judge the run from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_eeprom \
    -f filelist.f -o tb_eeprom > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_eeprom > sim.log 2>&1 || echo "simulator exited with an error status"
grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

/* src/bus_condition.sv */
`timescale 1ns/1ps

module bus_condition (
    input  logic            CLK,
    input  logic            RESET,
    input  logic            tick,
    input  i2c_pkg::phase_t phase,
    input  i2c_pkg::cond_t  cond,
    output logic            sda_low,
    output logic            cond_done
);
    import i2c_pkg::*;

    typedef enum logic [1:0] {
        c_idle,
        c_low,
        c_high
    } cstate_t;

    cstate_t cstate;
    cond_t   kind;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cstate  <= c_idle;
            kind    <= cond_none;
            sda_low <= 1'b0;
        end
        else
        begin
            case (cstate)
                c_idle:
                begin
                    if (cond != cond_none)
                    begin
                        kind    <= cond;
                        sda_low <= 1'b0;    // let go, the line follows the slave until scl falls
                        cstate  <= c_low;
                    end
                end
                c_low:
                begin
                    if (tick && phase == low_mid)
                    begin
                        sda_low <= (kind == cond_stop);
                        cstate  <= c_high;
                    end
                end
                default:
                begin
                    if (tick && phase == high_mid)
                    begin
                        sda_low <= (kind == cond_start);   // start keeps sda low
                        cstate  <= c_idle;
                    end
                end
            endcase
        end
    end

    assign cond_done = (cstate == c_high) && tick && (phase == high_mid);

endmodule

/* src/bus_timer.sv */
`timescale 1ns/1ps

module bus_timer #(
    parameter int QUARTER = i2c_pkg::QUARTER_DEFAULT
) (
    input  logic            CLK,
    input  logic            RESET,
    input  logic            run,
    output logic            scl,
    output logic            tick,
    output i2c_pkg::phase_t phase
);
    import i2c_pkg::*;

    localparam int CW = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    logic [CW-1:0] cnt;

    always_ff @(posedge CLK)
    begin
        if (RESET || !run)
        begin
            cnt   <= '0;
            phase <= high_first;   // idle bus rests with scl high
            tick  <= 1'b0;
        end
        else if (cnt == CW'(QUARTER - 1))
        begin
            cnt   <= '0;
            phase <= phase_t'(phase + 2'd1);
            tick  <= 1'b1;          // first cycle of the new quarter
        end
        else
        begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    assign scl = (phase == high_first) || (phase == high_mid);

endmodule

/* src/byte_shifter.sv */
`timescale 1ns/1ps

module byte_shifter (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              tick,
    input  i2c_pkg::phase_t   phase,
    input  logic              load,
    input  logic              receive,
    input  eeprom_pkg::data_t tx_byte,
    input  logic              sda_in,
    output logic              sda_low,
    output logic              byte_done,
    output logic              ack_seen,
    output eeprom_pkg::data_t rx_byte
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    data_t      shreg;
    logic [3:0] bit_cnt;   // 0..7 data, 8 is the ack slot
    logic       active;
    logic       rx;
    logic       drive_tick;
    logic       sample_tick;

    assign drive_tick  = active && tick && (phase == low_mid);
    assign sample_tick = active && tick && (phase == high_mid);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            rx      <= 1'b0;
            bit_cnt <= '0;
            sda_low <= 1'b0;
        end
        else if (load)
        begin
            active  <= 1'b1;
            rx      <= receive;
            bit_cnt <= '0;
            sda_low <= 1'b1;   // hold low until the first bit goes out
        end
        else if (drive_tick)
        begin
            if (bit_cnt < 4'd8)
                sda_low <= rx ? 1'b0 : !shreg[DATA_W-1];
            else
                sda_low <= !NACK_LEVEL;   // released for our nack or the slave ack
        end
        else if (sample_tick)
        begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd8)
                active <= 1'b0;
        end
    end

    // msb first; on a send the echoed bits shift in harmlessly
    always_ff @(posedge CLK)
    begin
        if (load)
            shreg <= tx_byte;
        else if (sample_tick && bit_cnt < 4'd8)
            shreg <= {shreg[DATA_W-2:0], sda_in};
    end

    assign byte_done = sample_tick && (bit_cnt == 4'd8);
    assign ack_seen  = byte_done && (sda_in == ACK_LEVEL);
    assign rx_byte   = shreg;

endmodule

/* src/eeprom_ctrl.sv */
`timescale 1ns/1ps

module eeprom_ctrl (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::data_t wdata,
    input  logic              cond_done,
    input  logic              byte_done,
    input  logic              ack_seen,
    input  eeprom_pkg::data_t rx_byte,
    output logic              run,
    output i2c_pkg::cond_t    cond,
    output logic              load,
    output logic              receive,
    output eeprom_pkg::data_t tx_byte,
    output logic              sel_cond,
    output logic              busy,
    output logic              done,
    output logic              nack_err,
    output eeprom_pkg::data_t rdata
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        idle, start, ctrl_write, addr_write, data_write,
        restart, ctrl_read, data_read, stop, finish
    } state_t;

    state_t state;
    addr_t  addr_q;
    data_t  wdata_q;
    logic   is_read;
    logic   missed_ack;

    // data_read ends on our own nack, never counted as missing
    assign missed_ack = byte_done && !ack_seen && (state != data_read);

    always_ff @(posedge CLK)
    begin
        if (state == idle && (wr || rd))
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
            is_read <= !wr;   // wr wins
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= idle;
            cond     <= cond_none;
            load     <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            nack_err <= 1'b0;
            rdata    <= '0;
        end
        else
        begin
            cond <= cond_none;
            load <= 1'b0;
            done <= 1'b0;
            if (missed_ack)
            begin
                nack_err <= 1'b1;
                cond     <= cond_stop;
                state    <= stop;
            end
            else
            begin
                case (state)
                    idle:
                    begin
                        if (wr || rd)
                        begin
                            busy     <= 1'b1;
                            nack_err <= 1'b0;
                            cond     <= cond_start;
                            state    <= start;
                        end
                    end
                    start:
                    begin
                        if (cond_done)
                        begin
                            load  <= 1'b1;
                            state <= ctrl_write;
                        end
                    end
                    ctrl_write:
                    begin
                        if (byte_done)
                        begin
                            load  <= 1'b1;
                            state <= addr_write;
                        end
                    end
                    addr_write:
                    begin
                        if (byte_done && is_read)
                        begin
                            cond  <= cond_start;   // repeated start
                            state <= restart;
                        end
                        else if (byte_done)
                        begin
                            load  <= 1'b1;
                            state <= data_write;
                        end
                    end
                    restart:
                    begin
                        if (cond_done)
                        begin
                            load  <= 1'b1;
                            state <= ctrl_read;
                        end
                    end
                    ctrl_read:
                    begin
                        if (byte_done)
                        begin
                            load  <= 1'b1;
                            state <= data_read;
                        end
                    end
                    data_write, data_read:
                    begin
                        if (byte_done)
                        begin
                            if (state == data_read)
                                rdata <= rx_byte;
                            cond  <= cond_stop;
                            state <= stop;
                        end
                    end
                    stop:
                    begin
                        if (cond_done)
                            state <= finish;
                    end
                    default:
                    begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= idle;
                    end
                endcase
            end
        end
    end

    // hand the pin over one cycle after the request, once the new owner has settled
    always_ff @(posedge CLK)
    begin
        if (RESET)
            sel_cond <= 1'b1;
        else if (cond != cond_none)
            sel_cond <= 1'b1;
        else if (load)
            sel_cond <= 1'b0;
    end

    // drops with the last cond_done so scl never falls after a stop
    assign run = (state != idle) && (state != finish) && !(state == stop && cond_done);

    assign receive = (state == data_read);

    always_comb
    begin
        case (state)
            ctrl_write: tx_byte = {DEVICE_CODE, addr_q[ADDR_W-1:DATA_W], 1'b0};
            ctrl_read:  tx_byte = {DEVICE_CODE, addr_q[ADDR_W-1:DATA_W], 1'b1};
            addr_write: tx_byte = addr_q[DATA_W-1:0];
            default:    tx_byte = wdata_q;
        endcase
    end

endmodule

/* src/eeprom_if_top.sv */
`timescale 1ns/1ps

module eeprom_if_top #(
    parameter int QUARTER = i2c_pkg::QUARTER_DEFAULT
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::data_t wdata,
    output logic              busy,
    output logic              done,
    output logic              nack_err,
    output eeprom_pkg::data_t rdata,
    output logic              scl,
    output logic              sda_low,
    input  logic              sda_in
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    logic   run, tick, load, receive, sel_cond;
    logic   cond_done, byte_done, ack_seen;
    logic   cond_sda_low, shift_sda_low;
    phase_t phase;
    cond_t  cond;
    data_t  tx_byte, rx_byte;

    bus_timer #(.QUARTER(QUARTER)) timer0 (
        .CLK(CLK), .RESET(RESET), .run(run), .scl(scl), .tick(tick), .phase(phase)
    );

    bus_condition cond0 (
        .CLK(CLK), .RESET(RESET), .tick(tick), .phase(phase), .cond(cond),
        .sda_low(cond_sda_low), .cond_done(cond_done)
    );

    byte_shifter shift0 (
        .CLK(CLK), .RESET(RESET), .tick(tick), .phase(phase), .load(load),
        .receive(receive), .tx_byte(tx_byte), .sda_in(sda_in), .sda_low(shift_sda_low),
        .byte_done(byte_done), .ack_seen(ack_seen), .rx_byte(rx_byte)
    );

    eeprom_ctrl ctrl0 (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .cond_done(cond_done), .byte_done(byte_done), .ack_seen(ack_seen),
        .rx_byte(rx_byte), .run(run), .cond(cond), .load(load), .receive(receive),
        .tx_byte(tx_byte), .sel_cond(sel_cond), .busy(busy), .done(done),
        .nack_err(nack_err), .rdata(rdata)
    );

    // only one driver owns the pin at a time
    assign sda_low = (sel_cond & cond_sda_low) | (!sel_cond & shift_sda_low);

endmodule

/* src/eeprom_pkg.sv */
package eeprom_pkg;

    // 2 Kbyte device: 3 block bits in the control byte, 8 bit word address
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // upper nibble of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage

/* src/i2c_pkg.sv */
package i2c_pkg;

    // quarters of one scl period, in bus order
    typedef enum logic [1:0] {
        low_first,
        low_mid,      // sda changes here
        high_first,
        high_mid      // sda sampled here
    } phase_t;

    // bus conditions requested by the control FSM
    typedef enum logic [1:0] {
        cond_none,
        cond_start,
        cond_stop
    } cond_t;

    localparam logic ACK_LEVEL  = 1'b0;
    localparam logic NACK_LEVEL = 1'b1;

    localparam int QUARTER_DEFAULT = 2;   // clk cycles per quarter

endpackage
